// ==== src_stream_pkg.sv ====
package src_stream_pkg;

  localparam int unsigned ADDR_W          = 32; // byte address
  localparam int unsigned STREAM_DW       = 32; // output stream default
  localparam int unsigned MEM_DW_EXTRA    = 32; // extra memory bits for misaligned loads
  localparam int unsigned CNT_W           = 16; // length and element counters
  localparam int unsigned OFS_W           = 2;  // byte offset in a 32-bit word
  localparam int unsigned DEFAULT_CREDITS = 4;  // outstanding loads

  // streamer control states
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0, // waiting for start
    ST_WORKING = 2'd1, // generator running
    ST_DRAIN   = 2'd2  // waiting for the last beats
  } streamer_state_e;

endpackage

// ==== src_fifo.sv ====
`timescale 1ns/100ps

module src_fifo #(
  parameter int unsigned DEPTH     = 2,
  parameter type         payload_t = logic [31:0]
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     push_valid_i,
  input  payload_t push_data_i,
  output logic     push_ready_o,
  output logic     pop_valid_o,
  output payload_t pop_data_o,
  input  logic     pop_ready_i,
  output logic     empty_o
);

  localparam int unsigned PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned FILL_W = $clog2(DEPTH + 1);

  payload_t          mem_q [DEPTH]; // circular storage
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [FILL_W-1:0] fill_q;        // entries in use
  logic              push;
  logic              pop;

  assign empty_o      = (fill_q == '0);
  assign push_ready_o = (fill_q != FILL_W'(DEPTH)); // not full
  assign pop_valid_o  = ~empty_o;
  assign pop_data_o   = mem_q[rd_ptr_q];             // head entry
  assign push         = push_valid_i & push_ready_o;
  assign pop          = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      fill_q   <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1; // wrap at depth
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      fill_q <= fill_q + FILL_W'(push) - FILL_W'(pop); // push and pop may coincide
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

// ==== src_pattern_gen.sv ====
`timescale 1ns/100ps

module src_pattern_gen #(
  parameter int unsigned CNT_W = src_stream_pkg::CNT_W
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              run_i,
  input  logic                              start_i,
  input  logic [src_stream_pkg::ADDR_W-1:0] base_addr_i,
  input  logic [CNT_W-1:0]                  tot_len_i,
  input  logic [CNT_W-1:0]                  d0_len_i,
  input  logic [src_stream_pkg::ADDR_W-1:0] d0_stride_i,
  input  logic [src_stream_pkg::ADDR_W-1:0] d1_stride_i,
  output logic                              off_valid_o,
  output logic [src_stream_pkg::ADDR_W-1:0] off_data_o,
  input  logic                              off_ready_i,
  output logic                              gen_done_o
);

  localparam int unsigned AW = src_stream_pkg::ADDR_W;

  logic             active_q;    // elements left in this job
  logic [CNT_W-1:0] elem_q;      // elements issued so far
  logic [CNT_W-1:0] idx_q;       // inner index
  logic [CNT_W-1:0] tot_len_q;
  logic [CNT_W-1:0] d0_len_q;
  logic [AW-1:0]    d0_stride_q;
  logic [AW-1:0]    d1_stride_q;
  logic [AW-1:0]    outer_q;     // base plus outer index times d1 stride
  logic [AW-1:0]    inner_q;     // inner index times d0 stride
  logic             load;
  logic             fire;
  logic             wrap;
  logic             last_elem;

  assign load        = start_i & ~active_q;
  assign off_valid_o = run_i & active_q;
  assign off_data_o  = outer_q + inner_q;
  assign fire        = off_valid_o & off_ready_i;
  assign wrap        = (idx_q == d0_len_q - 1'b1);  // end of inner run
  assign last_elem   = (elem_q == tot_len_q - 1'b1);
  assign gen_done_o  = fire & last_elem;            // last offset taken

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q <= 1'b0;
      elem_q   <= '0;
      idx_q    <= '0;
    end else if (load) begin
      active_q <= 1'b1;
      elem_q   <= '0;
      idx_q    <= '0;
    end else if (fire) begin
      active_q <= ~last_elem;
      elem_q   <= elem_q + 1'b1;
      idx_q    <= wrap ? '0 : idx_q + 1'b1;
    end
  end

  // config sampled at start, address accumulators
  always_ff @(posedge clk_i) begin
    if (load) begin
      tot_len_q   <= tot_len_i;
      d0_len_q    <= d0_len_i;
      d0_stride_q <= d0_stride_i;
      d1_stride_q <= d1_stride_i;
      outer_q     <= base_addr_i;
      inner_q     <= '0;
    end else if (fire) begin
      if (wrap) begin
        inner_q <= '0;
        outer_q <= outer_q + d1_stride_q; // next outer row
      end else begin
        inner_q <= inner_q + d0_stride_q;
      end
    end
  end

  a_d0_len_nonzero : assert property (@(posedge clk_i) disable iff (!rst_ni)
    load |-> (d0_len_i != '0))
    else $error("inner length is zero at start");

endmodule

// ==== src_bias_skip.sv ====
`timescale 1ns/100ps

module src_bias_skip #(
  parameter int unsigned CNT_W = src_stream_pkg::CNT_W
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              cnt_clr_i,
  input  logic                              ignore_bias_i,
  input  logic                              ignore_skip_i,
  input  logic                              off_valid_i,
  input  logic [src_stream_pkg::ADDR_W-1:0] off_data_i,
  output logic                              off_ready_o,
  input  logic                              bias_valid_i,
  input  logic [src_stream_pkg::ADDR_W-1:0] bias_data_i,
  output logic                              bias_ready_o,
  input  logic                              skip_valid_i,
  input  logic                              skip_data_i,
  output logic                              skip_ready_o,
  output logic                              addr_valid_o,
  output logic [src_stream_pkg::ADDR_W-1:0] addr_data_o,
  input  logic                              addr_ready_i,
  output logic [CNT_W-1:0]                  skip_count_o
);

  logic have_bias;  // bias present or not needed
  logic have_skip;  // skip flag present or not needed
  logic skip_flag;  // element to be dropped
  logic take;       // downstream can absorb this element
  logic skip_pulse;
  logic [CNT_W-1:0] skip_cnt_q;

  assign have_bias = bias_valid_i | ignore_bias_i;
  assign have_skip = skip_valid_i | ignore_skip_i;
  assign skip_flag = ~ignore_skip_i & skip_data_i;
  assign take      = skip_flag | addr_ready_i; // a skip needs no room

  assign addr_valid_o = off_valid_i & have_bias & have_skip & ~skip_flag;
  assign addr_data_o  = ignore_bias_i ? off_data_i : off_data_i + bias_data_i;
  assign off_ready_o  = have_bias & have_skip & take;
  assign bias_ready_o = ~ignore_bias_i & off_valid_i & have_skip & take; // consumed in lockstep
  assign skip_ready_o = ~ignore_skip_i & off_valid_i & have_bias & take;
  assign skip_pulse   = off_valid_i & have_bias & have_skip & skip_flag;
  assign skip_count_o = skip_cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      skip_cnt_q <= '0;
    end else if (cnt_clr_i) begin
      skip_cnt_q <= '0;                 // cleared at job end
    end else if (skip_pulse) begin
      skip_cnt_q <= skip_cnt_q + 1'b1;
    end
  end

  // a pending bias value stays put until the element takes it
  a_bias_held : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (bias_valid_i & ~bias_ready_o) |=> (bias_valid_i & $stable(bias_data_i)))
    else $error("bias valid dropped or data changed before it was taken");

endmodule

// ==== src_mem_issue.sv ====
`timescale 1ns/100ps

module src_mem_issue #(
  parameter int unsigned CREDITS         = src_stream_pkg::DEFAULT_CREDITS,
  parameter int unsigned ADDR_FIFO_DEPTH = 2
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              addr_valid_i,
  input  logic [src_stream_pkg::ADDR_W-1:0] addr_data_i,
  output logic                              addr_ready_o,
  output logic                              addr_empty_o,
  output logic                              mem_req_o,
  output logic [src_stream_pkg::ADDR_W-1:0] mem_addr_o,
  input  logic                              mem_gnt_i,
  output logic                              grant_ofs_valid_o,
  output logic [src_stream_pkg::OFS_W-1:0]  grant_ofs_o,
  input  logic                              credit_ret_i
);

  localparam int unsigned AW   = src_stream_pkg::ADDR_W;
  localparam int unsigned OW   = src_stream_pkg::OFS_W;
  localparam int unsigned CR_W = $clog2(CREDITS + 1);

  logic            head_valid;  // address waiting for issue
  logic [AW-1:0]   head_addr;
  logic            grant;
  logic [CR_W-1:0] credit_q;    // loads that may still be issued

  src_fifo #(
    .DEPTH     ( ADDR_FIFO_DEPTH ),
    .payload_t ( logic [AW-1:0]  )
  ) i_addr_fifo (
    .clk_i        ( clk_i        ),
    .rst_ni       ( rst_ni       ),
    .push_valid_i ( addr_valid_i ),
    .push_data_i  ( addr_data_i  ),
    .push_ready_o ( addr_ready_o ),
    .pop_valid_o  ( head_valid   ),
    .pop_data_o   ( head_addr    ),
    .pop_ready_i  ( grant        ),
    .empty_o      ( addr_empty_o )
  );

  assign mem_req_o         = head_valid & (credit_q != '0);   // held until granted
  assign mem_addr_o        = {head_addr[AW-1:OW], {OW{1'b0}}}; // word aligned
  assign grant             = mem_req_o & mem_gnt_i;
  assign grant_ofs_valid_o = grant;
  assign grant_ofs_o       = head_addr[OW-1:0]; // byte lane for realign

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      credit_q <= CR_W'(CREDITS);
    end else begin
      credit_q <= credit_q + CR_W'(credit_ret_i) - CR_W'(grant); // spend on grant, refill per beat
    end
  end

  a_credit_bound : assert property (@(posedge clk_i) disable iff (!rst_ni)
    credit_q <= CR_W'(CREDITS))
    else $error("credit count above the limit");

endmodule

// ==== src_realign.sv ====
`timescale 1ns/100ps

module src_realign #(
  parameter int unsigned STREAM_DW = src_stream_pkg::STREAM_DW,
  parameter int unsigned CREDITS   = src_stream_pkg::DEFAULT_CREDITS,
  parameter int unsigned CNT_W     = src_stream_pkg::CNT_W
) (
  input  logic                                                clk_i,
  input  logic                                                rst_ni,
  input  logic                                                cnt_clr_i,
  input  logic                                                grant_ofs_valid_i,
  input  logic [src_stream_pkg::OFS_W-1:0]                    grant_ofs_i,
  input  logic                                                mem_r_valid_i,
  input  logic [STREAM_DW+src_stream_pkg::MEM_DW_EXTRA-1:0]   mem_r_data_i,
  output logic                                                mem_r_ready_o,
  output logic                                                stream_valid_o,
  output logic [STREAM_DW-1:0]                                stream_data_o,
  input  logic                                                stream_ready_i,
  output logic                                                credit_ret_o,
  output logic [CNT_W-1:0]                                    beat_count_o
);

  localparam int unsigned OW = src_stream_pkg::OFS_W;

  logic             ofs_push_ready; // room for the granted offset
  logic             ofs_valid;      // oldest outstanding offset present
  logic [OW-1:0]    ofs_head;
  logic             beat;
  logic [CNT_W-1:0] beat_cnt_q;

  src_fifo #(
    .DEPTH     ( CREDITS        ),
    .payload_t ( logic [OW-1:0] )
  ) i_ofs_fifo (
    .clk_i        ( clk_i             ),
    .rst_ni       ( rst_ni            ),
    .push_valid_i ( grant_ofs_valid_i ),
    .push_data_i  ( grant_ofs_i       ),
    .push_ready_o ( ofs_push_ready    ),
    .pop_valid_o  ( ofs_valid         ),
    .pop_data_o   ( ofs_head          ),
    .pop_ready_i  ( beat              ),
    .empty_o      (                   )
  );

  assign mem_r_ready_o  = stream_ready_i; // memory holds data until taken
  assign stream_valid_o = mem_r_valid_i;
  assign stream_data_o  = mem_r_data_i[{ofs_head, 3'b000} +: STREAM_DW]; // byte shift
  assign beat           = mem_r_valid_i & stream_ready_i;
  assign credit_ret_o   = beat;
  assign beat_count_o   = beat_cnt_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      beat_cnt_q <= '0;
    end else if (cnt_clr_i) begin
      beat_cnt_q <= '0;
    end else if (beat) begin
      beat_cnt_q <= beat_cnt_q + 1'b1;
    end
  end

  a_resp_has_ofs : assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_r_valid_i |-> ofs_valid)
    else $error("response without an outstanding offset");

  // credits in mem_issue bound the loads in flight
  a_ofs_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_ni)
    grant_ofs_valid_i |-> ofs_push_ready)
    else $error("offset FIFO overflow");

endmodule

// ==== src_ctrl_fsm.sv ====
`timescale 1ns/100ps

module src_ctrl_fsm #(
  parameter int unsigned CNT_W = src_stream_pkg::CNT_W
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             start_i,
  input  logic [CNT_W-1:0] tot_len_i,
  input  logic             gen_done_i,
  input  logic             addr_empty_i,
  input  logic [CNT_W-1:0] skip_count_i,
  input  logic [CNT_W-1:0] beat_count_i,
  output logic             run_o,
  output logic             cnt_clr_o,
  output logic             ready_start_o,
  output logic             done_o
);

  src_stream_pkg::streamer_state_e state_q;
  src_stream_pkg::streamer_state_e state_d;
  logic                            drained; // every element streamed or skipped

  assign drained = addr_empty_i & ((beat_count_i + skip_count_i) == tot_len_i);

  always_comb begin
    state_d = state_q;
    done_o  = 1'b0;
    case (state_q)
      src_stream_pkg::ST_IDLE: begin
        if (start_i) begin
          state_d = src_stream_pkg::ST_WORKING;
        end
      end
      src_stream_pkg::ST_WORKING: begin
        if (gen_done_i) begin
          state_d = src_stream_pkg::ST_DRAIN; // last offset taken
        end
      end
      src_stream_pkg::ST_DRAIN: begin
        if (drained) begin
          state_d = src_stream_pkg::ST_IDLE;
          done_o  = 1'b1;                     // one cycle before idle
        end
      end
      default: state_d = src_stream_pkg::ST_IDLE;
    endcase
  end

  assign run_o         = (state_q == src_stream_pkg::ST_WORKING);
  assign ready_start_o = (state_q == src_stream_pkg::ST_IDLE);
  assign cnt_clr_o     = done_o; // counters restart for the next job

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= src_stream_pkg::ST_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== src_streamer_top.sv ====
`timescale 1ns/100ps

module src_streamer_top #(
  parameter int unsigned STREAM_DW       = src_stream_pkg::STREAM_DW,
  parameter int unsigned CNT_W           = src_stream_pkg::CNT_W,
  parameter int unsigned CREDITS         = src_stream_pkg::DEFAULT_CREDITS,
  parameter int unsigned ADDR_FIFO_DEPTH = 2
) (
  input  logic                                              clk_i,
  input  logic                                              rst_ni,
  input  logic                                              start_i,
  input  logic [src_stream_pkg::ADDR_W-1:0]                 base_addr_i,
  input  logic [CNT_W-1:0]                                  tot_len_i,
  input  logic [CNT_W-1:0]                                  d0_len_i,
  input  logic [src_stream_pkg::ADDR_W-1:0]                 d0_stride_i,
  input  logic [src_stream_pkg::ADDR_W-1:0]                 d1_stride_i,
  input  logic                                              ignore_bias_i,
  input  logic                                              ignore_skip_i,
  output logic                                              ready_start_o,
  output logic                                              done_o,
  input  logic                                              bias_valid_i,
  input  logic [src_stream_pkg::ADDR_W-1:0]                 bias_data_i,
  output logic                                              bias_ready_o,
  input  logic                                              skip_valid_i,
  input  logic                                              skip_data_i,
  output logic                                              skip_ready_o,
  output logic                                              stream_valid_o,
  output logic [STREAM_DW-1:0]                              stream_data_o,
  input  logic                                              stream_ready_i,
  output logic                                              mem_req_o,
  output logic [src_stream_pkg::ADDR_W-1:0]                 mem_addr_o,
  input  logic                                              mem_gnt_i,
  input  logic                                              mem_r_valid_i,
  input  logic [STREAM_DW+src_stream_pkg::MEM_DW_EXTRA-1:0] mem_r_data_i,
  output logic                                              mem_r_ready_o
);

  localparam int unsigned AW = src_stream_pkg::ADDR_W;

  logic                              start_go;    // start accepted in idle
  logic                              run;
  logic                              cnt_clr;
  logic                              off_valid;
  logic [AW-1:0]                     off_data;
  logic                              off_ready;
  logic                              gen_done;
  logic                              addr_valid;
  logic [AW-1:0]                     addr_data;
  logic                              addr_ready;
  logic                              addr_empty;
  logic                              grant_ofs_valid;
  logic [src_stream_pkg::OFS_W-1:0]  grant_ofs;
  logic                              credit_ret;
  logic [CNT_W-1:0]                  skip_count;
  logic [CNT_W-1:0]                  beat_count;

  assign start_go = start_i & ready_start_o;

  src_pattern_gen #(.CNT_W(CNT_W)) i_pattern_gen (
    .clk_i, .rst_ni, .run_i(run), .start_i(start_go), .base_addr_i, .tot_len_i,
    .d0_len_i, .d0_stride_i, .d1_stride_i, .off_valid_o(off_valid),
    .off_data_o(off_data), .off_ready_i(off_ready), .gen_done_o(gen_done)
  );

  src_bias_skip #(.CNT_W(CNT_W)) i_bias_skip (
    .clk_i, .rst_ni, .cnt_clr_i(cnt_clr), .ignore_bias_i, .ignore_skip_i,
    .off_valid_i(off_valid), .off_data_i(off_data), .off_ready_o(off_ready),
    .bias_valid_i, .bias_data_i, .bias_ready_o, .skip_valid_i, .skip_data_i, .skip_ready_o,
    .addr_valid_o(addr_valid), .addr_data_o(addr_data), .addr_ready_i(addr_ready),
    .skip_count_o(skip_count)
  );

  src_mem_issue #(.CREDITS(CREDITS), .ADDR_FIFO_DEPTH(ADDR_FIFO_DEPTH)) i_mem_issue (
    .clk_i, .rst_ni, .addr_valid_i(addr_valid), .addr_data_i(addr_data),
    .addr_ready_o(addr_ready), .addr_empty_o(addr_empty), .mem_req_o, .mem_addr_o,
    .mem_gnt_i, .grant_ofs_valid_o(grant_ofs_valid), .grant_ofs_o(grant_ofs),
    .credit_ret_i(credit_ret)
  );

  src_realign #(.STREAM_DW(STREAM_DW), .CREDITS(CREDITS), .CNT_W(CNT_W)) i_realign (
    .clk_i, .rst_ni, .cnt_clr_i(cnt_clr), .grant_ofs_valid_i(grant_ofs_valid),
    .grant_ofs_i(grant_ofs), .mem_r_valid_i, .mem_r_data_i, .mem_r_ready_o,
    .stream_valid_o, .stream_data_o, .stream_ready_i, .credit_ret_o(credit_ret),
    .beat_count_o(beat_count)
  );

  src_ctrl_fsm #(.CNT_W(CNT_W)) i_ctrl_fsm (
    .clk_i, .rst_ni, .start_i, .tot_len_i, .gen_done_i(gen_done),
    .addr_empty_i(addr_empty), .skip_count_i(skip_count), .beat_count_i(beat_count),
    .run_o(run), .cnt_clr_o(cnt_clr), .ready_start_o, .done_o
  );

endmodule

// ==== tb_src_streamer.sv ====
`timescale 1ns/100ps

module tb_src_streamer;

  localparam int unsigned MEM_SIZE = 4096; // bytes in the memory model

  logic        clk_i          = 1'b0;
  logic        rst_ni         = 1'b0;
  logic        start_i        = 1'b0;
  logic [31:0] base_addr_i    = '0;
  logic [15:0] tot_len_i      = '0;
  logic [15:0] d0_len_i       = 16'd1;
  logic [31:0] d0_stride_i    = '0;
  logic [31:0] d1_stride_i    = '0;
  logic        ignore_bias_i  = 1'b1;
  logic        ignore_skip_i  = 1'b1;
  logic        bias_valid_i   = 1'b0;
  logic [31:0] bias_data_i    = '0;
  logic        skip_valid_i   = 1'b0;
  logic        skip_data_i    = 1'b0;
  logic        stream_ready_i = 1'b0;
  logic        mem_gnt_i      = 1'b0;
  logic        mem_r_valid_i  = 1'b0;
  logic [63:0] mem_r_data_i   = '0;
  logic        ready_start_o, done_o, bias_ready_o, skip_ready_o;
  logic        stream_valid_o, mem_req_o, mem_r_ready_o;
  logic [31:0] stream_data_o, mem_addr_o;

  integer      seed        = 32'hf4f5_7afc;
  int          cyc         = 0;    // cycles since time zero
  int          cycle_limit = 1000; // grows by 200 per element
  int          done_count  = 0;
  int          beats_seen  = 0;
  int          exp_skips   = 0;
  int          exp_tot     = 0;
  int          bias_idx    = 0;
  int          skip_idx    = 0;
  logic        stall_mode  = 1'b0; // random ready and grant when set
  logic [7:0]  mem_bytes [MEM_SIZE];
  logic [31:0] exp_q [$];          // expected beats in order
  logic [31:0] bias_vals [$];
  logic        skip_vals [$];
  logic [31:0] resp_addr_q [$];    // granted word addresses
  int          resp_due_q [$];     // cycle when each response may show

  src_streamer_top dut (.*);

  initial begin
    forever #4 clk_i = ~clk_i; // 8 ns period
  end

  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = $random(seed);
    return lo + ((r & 'h7fff_ffff) % (hi - lo + 1));
  endfunction

  // little endian bytes as the memory holds them
  function automatic logic [31:0] exp_beat(input logic [31:0] a);
    logic [31:0] b;
    for (int k = 0; k < 4; k++) b[8*k +: 8] = mem_bytes[int'(a) + k];
    return b;
  endfunction

  function automatic logic [63:0] word_data(input logic [31:0] waddr);
    logic [63:0] d;
    for (int k = 0; k < 8; k++) d[8*k +: 8] = mem_bytes[int'(waddr) + k];
    return d;
  endfunction

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at cycle %0d", cyc);
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s: got 0x%0h expected 0x%0h", name, got, exp);
      stop_with_failure("value mismatch");
    end
  endtask

  task automatic check_idle();
    check_equal("ready_start_o", 32'(ready_start_o), 32'd1);
    check_equal("done_o", 32'(done_o), 32'd0);
    check_equal("stream_valid_o", 32'(stream_valid_o), 32'd0);
    check_equal("mem_req_o", 32'(mem_req_o), 32'd0);
    check_equal("bias_ready_o", 32'(bias_ready_o), 32'd0);
    check_equal("skip_ready_o", 32'(skip_ready_o), 32'd0);
  endtask

  task automatic run_job(input logic [31:0] base, input int tot, input int d0len,
                         input logic [31:0] d0s, input logic [31:0] d1s,
                         input logic ign_b, input logic ign_s);
    logic [31:0] addr;
    logic [31:0] bias;
    logic        skip;
    int          done_before;
    exp_q.delete();
    bias_vals.delete();
    skip_vals.delete();
    bias_idx   = 0;
    skip_idx   = 0;
    exp_skips  = 0;
    beats_seen = 0;
    exp_tot    = tot;
    for (int e = 0; e < tot; e++) begin
      bias = ign_b ? 32'd0 : 32'(rand_range(0, 15));
      skip = ign_s ? 1'b0 : (rand_range(0, 3) == 0); // about one in four dropped
      addr = base + 32'(e % d0len) * d0s + 32'(e / d0len) * d1s + bias;
      if (!ign_b) bias_vals.push_back(bias);
      if (!ign_s) skip_vals.push_back(skip);
      if (skip) exp_skips++;
      else exp_q.push_back(exp_beat(addr));
    end
    cycle_limit = cycle_limit + 200 * tot;
    @(posedge clk_i);
    check_idle();
    base_addr_i   <= base;
    tot_len_i     <= 16'(tot);
    d0_len_i      <= 16'(d0len);
    d0_stride_i   <= d0s;
    d1_stride_i   <= d1s;
    ignore_bias_i <= ign_b;
    ignore_skip_i <= ign_s;
    start_i       <= 1'b1;
    @(posedge clk_i);
    start_i     <= 1'b0;
    done_before = done_count;
    while (done_count == done_before) @(posedge clk_i);
    repeat (3) @(posedge clk_i);
    check_equal("done pulses", 32'(done_count - done_before), 32'd1);
    check_idle();
  endtask

  // memory model with in-order responses held until taken
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      mem_r_valid_i <= 1'b0;
      mem_gnt_i     <= 1'b0;
      resp_addr_q.delete();
      resp_due_q.delete();
    end else begin
      if (mem_r_valid_i && mem_r_ready_o) begin
        void'(resp_addr_q.pop_front());
        void'(resp_due_q.pop_front());
      end
      if (mem_req_o && mem_gnt_i) begin
        check_equal("mem_addr_o[1:0]", 32'(mem_addr_o[1:0]), 32'd0);
        resp_addr_q.push_back(mem_addr_o);
        resp_due_q.push_back(cyc + rand_range(1, 4)); // latency 1 to 4
      end
      if (resp_addr_q.size() > 0 && resp_due_q[0] <= cyc) begin
        mem_r_valid_i <= 1'b1;
        mem_r_data_i  <= word_data(resp_addr_q[0]);
      end else begin
        mem_r_valid_i <= 1'b0;
      end
      mem_gnt_i <= stall_mode ? (rand_range(0, 2) != 0) : 1'b1;
    end
  end

  // bias source with valid held until taken
  always @(posedge clk_i) begin
    if (bias_valid_i && bias_ready_o) bias_idx = bias_idx + 1;
    if (!(bias_valid_i && !bias_ready_o)) begin
      if (bias_idx < bias_vals.size() && rand_range(0, 3) != 0) begin
        bias_valid_i <= 1'b1;
        bias_data_i  <= bias_vals[bias_idx];
      end else begin
        bias_valid_i <= 1'b0;
      end
    end
  end

  // skip flag source
  always @(posedge clk_i) begin
    if (skip_valid_i && skip_ready_o) skip_idx = skip_idx + 1;
    if (!(skip_valid_i && !skip_ready_o)) begin
      if (skip_idx < skip_vals.size() && rand_range(0, 3) != 0) begin
        skip_valid_i <= 1'b1;
        skip_data_i  <= skip_vals[skip_idx];
      end else begin
        skip_valid_i <= 1'b0;
      end
    end
  end

  // output sink and end-of-job checks
  always @(posedge clk_i) begin
    if (rst_ni && stream_valid_o && stream_ready_i) begin
      if (exp_q.size() == 0) begin
        stop_with_failure("a beat arrived that no element accounts for");
      end else begin
        check_equal("stream_data_o", stream_data_o, exp_q.pop_front());
        beats_seen++;
      end
    end
    if (rst_ni && done_o) begin
      done_count++;
      if (exp_q.size() != 0) begin
        stop_with_failure("done_o came before every expected beat arrived");
      end
      check_equal("skip_count", 32'(dut.skip_count), 32'(exp_skips));
      check_equal("beats plus skips", 32'(beats_seen) + 32'(dut.skip_count), 32'(exp_tot));
    end
    stream_ready_i <= stall_mode ? (rand_range(0, 2) != 0) : 1'b1;
  end

  always @(posedge clk_i) begin
    cyc <= cyc + 1;
    if (cyc > cycle_limit) begin
      stop_with_failure("timeout, the job never finished");
    end
  end

  initial begin
    for (int i = 0; i < int'(MEM_SIZE); i++) begin
      mem_bytes[i] = 8'(i * 37) ^ 8'(i >> 5) ^ 8'h3c; // every address bit counts
    end
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(posedge clk_i);
    check_idle(); // state right after reset
    stall_mode = 1'b0;
    run_job(32'h100, 12, 4, 32'd4, 32'h40, 1'b1, 1'b1);   // plain aligned
    stall_mode = 1'b1;
    run_job(32'h203, 16, 5, 32'd3, 32'd37, 1'b0, 1'b1);   // misaligned with bias
    run_job(32'h041, 20, 3, 32'd6, 32'd29, 1'b0, 1'b0);   // skips and bias
    run_job(32'(rand_range(0, 255)), 32, rand_range(1, 6), 32'(rand_range(0, 8)),
            32'(rand_range(0, 64)), 1'b0, 1'b0);          // random shape
    stall_mode = 1'b0;
    run_job(32'h380, 9, 3, 32'd8, 32'd100, 1'b1, 1'b1);   // new plain settings
    $display("RESULT: PASS");
    $finish;
  end

endmodule

// ==== src_streamer_top.f ====
src_stream_pkg.sv
src_fifo.sv
src_pattern_gen.sv
src_bias_skip.sv
src_mem_issue.sv
src_realign.sv
src_ctrl_fsm.sv
src_streamer_top.sv
tb_src_streamer.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build the streamer testbench with Verilator, run it and scan the log
set -o pipefail
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_src_streamer \
  -f src_streamer_top.f -Mdir obj_dir \
  && ./obj_dir/Vtb_src_streamer 2>&1 | tee sim.log \
  && ! grep -q "RESULT: FAIL" sim.log \
  || { echo "simulation failed"; exit 1; }
echo "simulation passed"
